/* cache_types_pkg.sv */
package cache_types_pkg;

    // address and data word
    localparam int WORD_BITS = 32;

    // address fields, tag | set | offset
    localparam int OFFSET_BITS = 4;
    localparam int SET_BITS = 4;
    localparam int TAG_BITS = WORD_BITS - SET_BITS - OFFSET_BITS;

    localparam int NUM_SETS = 1 << SET_BITS;

    localparam int BYTE_SEL_BITS = $clog2(WORD_BITS / 8);

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
        logic [OFFSET_BITS-BYTE_SEL_BITS-1:0] word_sel; // word within the line
        logic [BYTE_SEL_BITS-1:0] byte_sel;             // byte within the word
    } cache_addr_fields_t;

    // same word, raw byte address or decoded fields
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef enum logic [1:0] {
        dirty_keep  = 2'd0,
        dirty_set   = 2'd1,
        dirty_clear = 2'd2
    } dirty_op_e;

    typedef enum logic {
        valid_keep = 1'b0,
        valid_set  = 1'b1
    } valid_op_e;

    typedef enum logic [1:0] {
        data_none  = 2'd0,
        data_merge = 2'd1, // masked cpu bytes into the hit way
        data_fill  = 2'd2  // whole line from memory into the victim way
    } data_wr_e;

endpackage

/* mem_types_pkg.sv */
package mem_types_pkg;

    // one cache line per memory transfer
    localparam int LINE_BITS = 128;
    localparam int WORDS_PER_LINE = 4;

    typedef enum logic [1:0] {
        cmd_idle  = 2'd0,
        cmd_read  = 2'd1, // line fill
        cmd_write = 2'd2  // victim write-back
    } mem_cmd_e;

endpackage

/* cpu_req_port.sv */
`timescale 1ns/1ps

module cpu_req_port (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    output logic req_ready,
    input  logic req_write,
    input  cache_types_pkg::cache_addr_u req_addr,
    input  logic [cache_types_pkg::WORD_BITS-1:0] req_wdata,
    input  logic [cache_types_pkg::WORD_BITS/8-1:0] req_wmask,
    output logic resp_valid,
    input  logic resp_ready,
    output logic [cache_types_pkg::WORD_BITS-1:0] resp_rdata,
    output logic cpu_read,
    output logic cpu_write,
    output cache_types_pkg::cache_addr_u cpu_addr,
    output logic [cache_types_pkg::WORD_BITS-1:0] cpu_wdata,
    output logic [cache_types_pkg::WORD_BITS/8-1:0] cpu_wmask,
    input  logic done,
    input  logic aborted,
    input  logic [cache_types_pkg::WORD_BITS-1:0] done_rdata
);

    logic busy;    // from acceptance until the response is taken
    logic pending; // request still owned by the controller
    logic write_q;

    assign req_ready = ~busy;
    assign cpu_read = pending & ~write_q;
    assign cpu_write = pending & write_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b1; // not ready while in reset
            pending <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                busy <= 1'b1;
                pending <= 1'b1;
            end else if (aborted) begin
                busy <= 1'b0; // dropped, no response
                pending <= 1'b0;
            end else if (done) begin
                pending <= 1'b0;
                resp_valid <= 1'b1;
            end else if (resp_valid && resp_ready) begin
                busy <= 1'b0;
                resp_valid <= 1'b0;
            end else if (!pending && !resp_valid) begin
                busy <= 1'b0; // first cycle out of reset
            end
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_q <= req_write;
            cpu_addr <= req_addr;
            cpu_wdata <= req_wdata;
            cpu_wmask <= req_wmask;
        end
        if (done) begin
            resp_rdata <= done_rdata;
        end
    end

endmodule

/* d_cache_control.sv */
`timescale 1ns/1ps

module d_cache_control (
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_read,
    input  logic cpu_write,
    input  logic cancel,
    input  logic cache_hit,
    input  logic victim_dirty,
    input  logic mem_done,
    output logic done,
    output logic aborted,
    output cache_types_pkg::dirty_op_e dirty_op,
    output cache_types_pkg::valid_op_e valid_op,
    output cache_types_pkg::data_wr_e data_wr,
    output logic tag_we,
    output logic plru_update,
    output logic victim_sel,
    output logic evict_addr_sel,
    output mem_types_pkg::mem_cmd_e mem_cmd
);

    import cache_types_pkg::*;
    import mem_types_pkg::*;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        lookup     = 2'd1,
        write_back = 2'd2,
        allocate   = 2'd3
    } state_e;

    state_e state, next_state;

    logic req_pending;

    assign req_pending = cpu_read | cpu_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    task automatic set_defaults();
        done = 1'b0;
        aborted = 1'b0;
        dirty_op = dirty_keep;
        valid_op = valid_keep;
        data_wr = data_none;
        tag_we = 1'b0;
        plru_update = 1'b0;
        victim_sel = 1'b0;
        evict_addr_sel = 1'b0;
        mem_cmd = cmd_idle;
    endtask

    always_comb begin
        set_defaults();
        next_state = state;
        case (state)
            idle: begin
                if (req_pending) next_state = lookup;
            end
            lookup: begin
                if (cancel) begin
                    // abandoned before anything is written
                    aborted = 1'b1;
                    next_state = idle;
                end else if (cache_hit) begin
                    done = 1'b1;
                    plru_update = 1'b1;
                    if (cpu_write) begin
                        data_wr = data_merge; // hit way
                        dirty_op = dirty_set;
                    end
                    next_state = idle;
                end else if (victim_dirty) begin
                    next_state = write_back;
                end else begin
                    next_state = allocate;
                end
            end
            write_back: begin
                mem_cmd = cmd_write;
                evict_addr_sel = 1'b1; // victim tag and set
                if (mem_done) begin
                    victim_sel = 1'b1;
                    dirty_op = dirty_clear;
                    next_state = allocate;
                end
            end
            allocate: begin
                mem_cmd = cmd_read; // request's own line address
                if (mem_done) begin
                    data_wr = data_fill;
                    tag_we = 1'b1;
                    valid_op = valid_set;
                    next_state = lookup; // hits this time
                end
            end
            default: next_state = idle;
        endcase
    end

endmodule

/* d_cache_datapath.sv */
`timescale 1ns/1ps

module d_cache_datapath (
    input  logic clk,
    input  logic rst_n,
    input  cache_types_pkg::cache_addr_u cpu_addr,
    input  logic [cache_types_pkg::WORD_BITS-1:0] cpu_wdata,
    input  logic [cache_types_pkg::WORD_BITS/8-1:0] cpu_wmask,
    input  cache_types_pkg::dirty_op_e dirty_op,
    input  cache_types_pkg::valid_op_e valid_op,
    input  cache_types_pkg::data_wr_e data_wr,
    input  logic tag_we,
    input  logic plru_update,
    input  logic victim_sel,
    input  logic evict_addr_sel,
    input  logic [mem_types_pkg::LINE_BITS-1:0] fill_line,
    output logic cache_hit,
    output logic victim_dirty,
    output logic [cache_types_pkg::WORD_BITS-1:0] rdata,
    output logic [mem_types_pkg::LINE_BITS-1:0] line_out,
    output logic [cache_types_pkg::WORD_BITS-1:0] line_addr
);

    import cache_types_pkg::*;
    import mem_types_pkg::*;

    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);

    logic [TAG_BITS-1:0] tag_mem [2][NUM_SETS];
    logic [LINE_BITS-1:0] data_mem [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0] plru_q; // way not most recently hit

    logic [TAG_BITS-1:0] tag_req;
    logic [SET_BITS-1:0] set_idx;
    logic [WSEL_BITS-1:0] word_idx;
    logic [1:0] hit_way;
    logic hit_idx;
    logic victim_idx;
    logic dirty_way;
    logic [LINE_BITS-1:0] hit_line;
    logic [LINE_BITS-1:0] merged_line;

    assign tag_req = cpu_addr.fields.tag;
    assign set_idx = cpu_addr.fields.set;
    assign word_idx = cpu_addr.fields.word_sel;

    // both ways compared in parallel
    assign hit_way[0] = valid_q[0][set_idx] && (tag_mem[0][set_idx] == tag_req);
    assign hit_way[1] = valid_q[1][set_idx] && (tag_mem[1][set_idx] == tag_req);
    assign cache_hit = |hit_way;
    assign hit_idx = hit_way[1];

    assign victim_idx = plru_q[set_idx];
    assign victim_dirty = dirty_q[victim_idx][set_idx];
    assign dirty_way = victim_sel ? victim_idx : hit_idx;

    assign hit_line = data_mem[hit_idx][set_idx];
    assign rdata = hit_line[word_idx*WORD_BITS +: WORD_BITS];
    assign line_out = data_mem[victim_idx][set_idx];

    always_comb begin
        if (evict_addr_sel) begin
            line_addr = {tag_mem[victim_idx][set_idx], set_idx, {OFFSET_BITS{1'b0}}};
        end else begin
            line_addr = {tag_req, set_idx, {OFFSET_BITS{1'b0}}};
        end
    end

    // byte merge into the addressed word
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < WORD_BITS / 8; b++) begin
            if (cpu_wmask[b]) begin
                merged_line[word_idx*WORD_BITS + b*8 +: 8] = cpu_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q <= '0;
        end else begin
            case (dirty_op)
                dirty_set: dirty_q[dirty_way][set_idx] <= 1'b1;
                dirty_clear: dirty_q[dirty_way][set_idx] <= 1'b0;
                default: ;
            endcase
            if (valid_op == valid_set) begin
                valid_q[victim_idx][set_idx] <= 1'b1; // filled way is the victim
            end
            if (plru_update) begin
                plru_q[set_idx] <= ~hit_idx; // point away from the hit way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr == data_merge) begin
            data_mem[hit_idx][set_idx] <= merged_line;
        end else if (data_wr == data_fill) begin
            data_mem[victim_idx][set_idx] <= fill_line;
        end
        if (tag_we) begin
            tag_mem[victim_idx][set_idx] <= tag_req;
        end
    end

endmodule

/* mem_port.sv */
`timescale 1ns/1ps

module mem_port (
    input  logic clk,
    input  logic rst_n,
    input  mem_types_pkg::mem_cmd_e mem_cmd,
    input  logic [cache_types_pkg::WORD_BITS-1:0] line_addr,
    input  logic [mem_types_pkg::LINE_BITS-1:0] line_out,
    output logic mem_done,
    output logic [mem_types_pkg::LINE_BITS-1:0] fill_line,
    output logic mem_req_valid,
    input  logic mem_req_ready,
    output logic mem_req_write,
    output logic [cache_types_pkg::WORD_BITS-1:0] mem_req_addr,
    output logic [mem_types_pkg::LINE_BITS-1:0] mem_req_wdata,
    input  logic mem_resp_valid,
    input  logic [mem_types_pkg::LINE_BITS-1:0] mem_resp_rdata
);

    import mem_types_pkg::*;

    typedef enum logic [1:0] {
        port_idle  = 2'd0,
        requesting = 2'd1,
        waiting    = 2'd2
    } port_state_e;

    port_state_e state_q;
    logic start;

    // cmd is still held during the mem_done cycle, don't reissue it
    assign start = (state_q == port_idle) && (mem_cmd != cmd_idle) && !mem_done;
    assign mem_req_valid = (state_q == requesting);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= port_idle;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state_q)
                port_idle: if (start) state_q <= requesting;
                requesting: if (mem_req_ready) state_q <= waiting;
                waiting: begin
                    if (mem_resp_valid) begin
                        state_q <= port_idle;
                        mem_done <= 1'b1;
                    end
                end
                default: state_q <= port_idle;
            endcase
        end
    end

    // steady request under back-pressure
    always_ff @(posedge clk) begin
        if (start) begin
            mem_req_write <= (mem_cmd == cmd_write);
            mem_req_addr <= line_addr;
            mem_req_wdata <= line_out;
        end
        if (state_q == waiting && mem_resp_valid && !mem_req_write) begin
            fill_line <= mem_resp_rdata; // last read response
        end
    end

endmodule

/* d_cache_top.sv */
`timescale 1ns/1ps

module d_cache_top (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    output logic req_ready,
    input  logic req_write,
    input  logic [cache_types_pkg::WORD_BITS-1:0] req_addr,
    input  logic [cache_types_pkg::WORD_BITS-1:0] req_wdata,
    input  logic [cache_types_pkg::WORD_BITS/8-1:0] req_wmask,
    output logic resp_valid,
    input  logic resp_ready,
    output logic [cache_types_pkg::WORD_BITS-1:0] resp_rdata,
    input  logic cancel,
    output logic mem_req_valid,
    input  logic mem_req_ready,
    output logic mem_req_write,
    output logic [cache_types_pkg::WORD_BITS-1:0] mem_req_addr,
    output logic [mem_types_pkg::LINE_BITS-1:0] mem_req_wdata,
    input  logic mem_resp_valid,
    input  logic [mem_types_pkg::LINE_BITS-1:0] mem_resp_rdata
);

    import cache_types_pkg::*;
    import mem_types_pkg::*;

    // port <-> controller
    logic cpu_read;
    logic cpu_write;
    cache_addr_u cpu_addr;
    logic [WORD_BITS-1:0] cpu_wdata;
    logic [WORD_BITS/8-1:0] cpu_wmask;
    logic done;
    logic aborted;
    logic [WORD_BITS-1:0] rdata;

    // controller -> datapath
    dirty_op_e dirty_op;
    valid_op_e valid_op;
    data_wr_e data_wr;
    logic tag_we;
    logic plru_update;
    logic victim_sel;
    logic evict_addr_sel;
    logic cache_hit;
    logic victim_dirty;

    // controller/datapath <-> memory side
    mem_cmd_e mem_cmd;
    logic mem_done;
    logic [LINE_BITS-1:0] fill_line;
    logic [LINE_BITS-1:0] line_out;
    logic [WORD_BITS-1:0] line_addr;

    cpu_req_port cpu_req_port_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wmask(req_wmask),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
        .cpu_read(cpu_read), .cpu_write(cpu_write), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_wmask(cpu_wmask),
        .done(done), .aborted(aborted), .done_rdata(rdata)
    );

    d_cache_control d_cache_control_i (
        .clk(clk), .rst_n(rst_n),
        .cpu_read(cpu_read), .cpu_write(cpu_write), .cancel(cancel),
        .cache_hit(cache_hit), .victim_dirty(victim_dirty), .mem_done(mem_done),
        .done(done), .aborted(aborted),
        .dirty_op(dirty_op), .valid_op(valid_op), .data_wr(data_wr),
        .tag_we(tag_we), .plru_update(plru_update), .victim_sel(victim_sel),
        .evict_addr_sel(evict_addr_sel), .mem_cmd(mem_cmd)
    );

    d_cache_datapath d_cache_datapath_i (
        .clk(clk), .rst_n(rst_n),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wmask(cpu_wmask),
        .dirty_op(dirty_op), .valid_op(valid_op), .data_wr(data_wr),
        .tag_we(tag_we), .plru_update(plru_update), .victim_sel(victim_sel),
        .evict_addr_sel(evict_addr_sel), .fill_line(fill_line),
        .cache_hit(cache_hit), .victim_dirty(victim_dirty), .rdata(rdata),
        .line_out(line_out), .line_addr(line_addr)
    );

    mem_port mem_port_i (
        .clk(clk), .rst_n(rst_n),
        .mem_cmd(mem_cmd), .line_addr(line_addr), .line_out(line_out),
        .mem_done(mem_done), .fill_line(fill_line),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write), .mem_req_addr(mem_req_addr),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

endmodule

/* d_cache_assertions.sv */
`timescale 1ns/1ps

module d_cache_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_ready,
    input logic req_write,
    input logic [31:0] req_addr,
    input logic resp_valid,
    input logic resp_ready,
    input logic [31:0] resp_rdata,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input logic mem_req_write,
    input logic [31:0] mem_req_addr,
    input logic aborted
);

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_ready) |=> req_valid && $stable(req_addr) && $stable(req_write))
    else $error("request dropped or changed before req_ready");

    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && !resp_ready) |=> resp_valid && $stable(resp_rdata))
    else $error("response dropped or changed before resp_ready");

    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && !mem_req_ready) |=> mem_req_valid && $stable(mem_req_addr)
            && $stable(mem_req_write))
    else $error("memory request dropped or changed before mem_req_ready");

    // one request in flight
    busy_while_resp: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !req_ready)
    else $error("req_ready high while a response is pending");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_req_valid && !resp_valid)
    else $error("valid outputs not low after reset");

    // long enough for a leftover lookup to respond, too short for the next request
    cancel_no_resp: assert property (@(posedge clk) disable iff (!rst_n)
        aborted |=> !resp_valid ##1 !resp_valid ##1 !resp_valid)
    else $error("cancelled request produced a response");

endmodule

bind d_cache_top d_cache_assertions assertions_i (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
    .req_addr(req_addr),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_req_write(mem_req_write), .mem_req_addr(mem_req_addr),
    .aborted(aborted)
);

/* tb_d_cache.sv */
`timescale 1ns/1ps

module tb_d_cache;

    localparam int RANDOM_REQ = 150;
    localparam int DIRECTED_REQ = 14; // issue calls before the random run
    localparam int NUM_REQ = DIRECTED_REQ + RANDOM_REQ;
    localparam int WORST_MISS = 30;  // write-back, fill and lookups in cycles
    localparam int CYCLE_LIMIT = 40 * NUM_REQ * WORST_MISS;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic req_valid = 1'b0;
    logic req_write = 1'b0;
    logic [31:0] req_addr = '0;
    logic [31:0] req_wdata = '0;
    logic [3:0] req_wmask = '0;
    logic resp_ready = 1'b0;
    logic cancel = 1'b0;
    logic mem_req_ready = 1'b0;
    logic mem_resp_valid = 1'b0;
    logic [127:0] mem_resp_rdata = '0;
    logic req_ready;
    logic resp_valid;
    logic [31:0] resp_rdata;
    logic mem_req_valid;
    logic mem_req_write;
    logic [31:0] mem_req_addr;
    logic [127:0] mem_req_wdata;

    logic [127:0] mem_lines [64];  // 1 KB window
    logic [31:0] shadow [256];     // word view of the same window
    logic [127:0] pending_line;
    logic [2:0] resp_delay;
    logic mem_busy = 1'b0;
    logic exp_read = 1'b0;
    logic [31:0] exp_rdata = '0;
    logic [127:0] wb_exp;
    logic check_latency = 1'b0;
    logic stall_resp = 1'b0;
    string test_name = "reset";
    int errors = 0;
    int cycles = 0;

    d_cache_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    // memory model, random ready and a 1 to 6 cycle response
    always @(posedge clk) begin
        mem_resp_valid <= 1'b0;
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            mem_busy <= 1'b1;
            mem_req_ready <= 1'b0;
            resp_delay <= 3'(1 + $urandom % 6);
            pending_line <= mem_lines[mem_req_addr[9:4]];
            if (mem_req_write) mem_lines[mem_req_addr[9:4]] <= mem_req_wdata;
        end else if (mem_busy) begin
            if (resp_delay == 3'd1) begin
                mem_resp_valid <= 1'b1;
                mem_resp_rdata <= pending_line;
                mem_busy <= 1'b0;
            end else begin
                resp_delay <= resp_delay - 3'd1;
            end
        end else begin
            mem_req_ready <= ($urandom % 4) != 0;
        end
    end

    // shadow memory and expected read word, taken at acceptance
    always @(posedge clk) begin
        if (req_valid && req_ready) begin
            exp_read <= !req_write;
            exp_rdata <= shadow[req_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (req_write && req_wmask[b]) shadow[req_addr[9:2]][b*8 +: 8] <= req_wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        wb_exp = {shadow[{mem_req_addr[9:4], 2'd3}], shadow[{mem_req_addr[9:4], 2'd2}],
                  shadow[{mem_req_addr[9:4], 2'd1}], shadow[{mem_req_addr[9:4], 2'd0}]};
    end

    always @(posedge clk) resp_ready <= stall_resp ? 1'($urandom) : 1'b1;

    read_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_ready && exp_read) |-> resp_rdata == exp_rdata)
    else begin
        $display("FAILED %s: expected %h, actual %h", test_name,
                 $sampled(exp_rdata), $sampled(resp_rdata));
        errors++;
    end

    write_back_check: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready && mem_req_write) |-> mem_req_wdata == wb_exp)
    else begin
        $display("FAILED %s: expected %h, actual %h", test_name,
                 $sampled(wb_exp), $sampled(mem_req_wdata));
        errors++;
    end

    // hit latency, resp_valid low after edges N and N+1, high after edge N+2
    hit_latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready && check_latency)
            |-> ##1 !resp_valid ##1 !resp_valid ##1 resp_valid)
    else begin
        $display("FAILED %s: expected resp_valid rising two edges after acceptance, actual %b",
                 test_name, $sampled(resp_valid));
        errors++;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic issue(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] mask, input bit do_cancel);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr <= addr;
        req_wdata <= data;
        req_wmask <= mask;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0; // accepted on this edge
        if (do_cancel) begin
            @(posedge clk);
            cancel <= 1'b1; // lookup cycle
            @(posedge clk);
            cancel <= 1'b0;
            do @(posedge clk); while (!req_ready);
        end else begin
            do @(posedge clk); while (!(resp_valid && resp_ready));
        end
    endtask

    initial begin
        void'($urandom(79942));
        for (int i = 0; i < 256; i++) shadow[i] = init_word(32'(i * 4));
        for (int l = 0; l < 64; l++) begin
            mem_lines[l] = {init_word(32'(l*16 + 12)), init_word(32'(l*16 + 8)),
                            init_word(32'(l*16 + 4)), init_word(32'(l*16))};
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_name = "cold_read";
        issue(1'b0, 32'h010, '0, '0, 1'b0);
        issue(1'b0, 32'h024, '0, '0, 1'b0);
        issue(1'b0, 32'h038, '0, '0, 1'b0);

        test_name = "read_hit";
        check_latency <= 1'b1;
        issue(1'b0, 32'h010, '0, '0, 1'b0);
        issue(1'b0, 32'h014, '0, '0, 1'b0);
        check_latency <= 1'b0;

        test_name = "write_merge";
        issue(1'b1, 32'h024, 32'hdeadbeef, 4'b0101, 1'b0);
        issue(1'b0, 32'h024, '0, '0, 1'b0);

        // set 5, tags 0, 1, 2
        test_name = "dirty_evict";
        issue(1'b0, 32'h050, '0, '0, 1'b0);
        issue(1'b1, 32'h154, 32'h12345678, 4'b1111, 1'b0);
        issue(1'b0, 32'h050, '0, '0, 1'b0);
        issue(1'b0, 32'h250, '0, '0, 1'b0); // evicts the dirty tag 1 line
        issue(1'b0, 32'h154, '0, '0, 1'b0);

        test_name = "cancel_lookup";
        issue(1'b0, 32'h060, '0, '0, 1'b1);
        issue(1'b0, 32'h060, '0, '0, 1'b0);

        test_name = "resp_backpressure";
        stall_resp <= 1'b1;
        for (int n = 0; n < RANDOM_REQ; n++) begin
            issue(1'($urandom), {22'd0, 8'($urandom), 2'b00}, $urandom, 4'($urandom), 1'b0);
        end
        stall_resp <= 1'b0;
        repeat (3) @(posedge clk);

        $display("errors: %0d failed checks", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* files.f */
cache_types_pkg.sv
mem_types_pkg.sv
cpu_req_port.sv
d_cache_control.sv
d_cache_datapath.sv
mem_port.sv
d_cache_top.sv
d_cache_assertions.sv
tb_d_cache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_d_cache
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
